// File: cc_tag_params.svh
`ifndef CC_TAG_PARAMS_SVH
`define CC_TAG_PARAMS_SVH

// Directory geometry
`define CC_WAYS 4
`define CC_SETS 64

// Address split, line address = {tag, index}
`define CC_INDEX_W 6
`define CC_TAG_W 18
`define CC_LINE_W 24

// Tag entry layout {parity, valid, tag}
`define CC_ENTRY_W 20
`define CC_VALID_BIT 18
`define CC_PARITY_BIT 19

// Tree PLRU bits per set
`define CC_PLRU_W 3

`endif

// File: cc_tag_pkg.sv
`default_nettype none

`include "cc_tag_params.svh"

package cc_tag_pkg;

  // Physical line address, index in the low bits
  typedef logic [`CC_LINE_W-1:0] line_addr_t;
  typedef logic [`CC_INDEX_W-1:0] index_t;
  typedef logic [`CC_TAG_W-1:0] tag_t;

  // Stored entry XORs to zero when intact
  typedef logic [`CC_ENTRY_W-1:0] tag_entry_t;

  typedef logic [1:0] way_t;
  typedef logic [`CC_WAYS-1:0] way_mask_t;

  // Bit 0 root, bit 1 ways 0-1, bit 2 ways 2-3
  typedef logic [`CC_PLRU_W-1:0] plru_t;

  typedef enum logic {
    INIT_SWEEP,
    INIT_DONE
  } init_state_t;

endpackage

`default_nettype wire

// File: cc_tag_ram.sv
`timescale 1ns/1ns
`default_nettype none

`include "cc_tag_params.svh"

module cc_tag_ram #(
  parameter int data_w = `CC_ENTRY_W,
  parameter int depth = `CC_SETS
) (
  input logic clk,
  input logic rst,
  input logic read_en,
  input logic write_en,
  input cc_tag_pkg::index_t read_addr,
  input cc_tag_pkg::index_t write_addr,
  input logic [data_w-1:0] write_data,
  output logic [data_w-1:0] read_data
);

  logic [data_w-1:0] mem [depth];
  cc_tag_pkg::index_t read_addr_q;

  // Address held between reads
  always_ff @(posedge clk) begin
    if (rst) begin
      read_addr_q <= '0;
    end else if (read_en) begin
      read_addr_q <= read_addr;
    end
  end

  always_ff @(posedge clk) begin
    if (write_en) begin
      mem[write_addr] <= write_data;
    end
  end

  assign read_data = mem[read_addr_q]; // Array output after the address register

endmodule

`default_nettype wire

// File: cc_tag_way.sv
`timescale 1ns/1ns
`default_nettype none

`include "cc_tag_params.svh"

module cc_tag_way (
  input logic clk,
  input logic rst,
  input logic read_en,
  input logic write_en,
  input logic clear,
  input cc_tag_pkg::index_t read_addr,
  input cc_tag_pkg::tag_t read_tag,
  input cc_tag_pkg::index_t fill_addr,
  input logic fill_read_en,
  input cc_tag_pkg::index_t write_index,
  input cc_tag_pkg::tag_t write_tag,
  output logic read_hit,
  output logic read_err,
  output cc_tag_pkg::tag_entry_t fill_entry
);

  cc_tag_pkg::tag_entry_t entry_new;
  cc_tag_pkg::tag_entry_t write_entry;
  cc_tag_pkg::tag_entry_t lookup_entry;
  logic parity_new;

  // Even parity over valid and tag
  assign parity_new = ~(^write_tag);

  always_comb begin
    entry_new = '0;
    entry_new[`CC_PARITY_BIT] = parity_new;
    entry_new[`CC_VALID_BIT] = 1'b1;
    entry_new[`CC_TAG_W-1:0] = write_tag;
  end

  assign write_entry = clear ? '0 : entry_new; // Invalidate and init write zeros

  // Lookup copy, addressed by the read port
  cc_tag_ram #(
    .data_w(`CC_ENTRY_W),
    .depth(`CC_SETS)
  ) u_lookup_ram (
    .clk(clk),
    .rst(rst),
    .read_en(read_en),
    .write_en(write_en),
    .read_addr(read_addr),
    .write_addr(write_index),
    .write_data(write_entry),
    .read_data(lookup_entry)
  );

  // Fill copy, addressed by the fill or invalidate index
  cc_tag_ram #(
    .data_w(`CC_ENTRY_W),
    .depth(`CC_SETS)
  ) u_fill_ram (
    .clk(clk),
    .rst(rst),
    .read_en(fill_read_en),
    .write_en(write_en),
    .read_addr(fill_addr),
    .write_addr(write_index),
    .write_data(write_entry),
    .read_data(fill_entry)
  );

  assign read_hit = lookup_entry[`CC_VALID_BIT] &&
                    (lookup_entry[`CC_TAG_W-1:0] == read_tag);
  assign read_err = ^lookup_entry;

  // Every write carries good parity, so a parity error never shows up next to a hit
  a_hit_no_err: assert property (@(posedge clk) disable iff (rst)
    read_err |-> !read_hit);

endmodule

`default_nettype wire

// File: cc_plru.sv
`timescale 1ns/1ns
`default_nettype none

module cc_plru (
  input cc_tag_pkg::plru_t state,
  input cc_tag_pkg::way_t touch_way,
  output cc_tag_pkg::way_t victim,
  output cc_tag_pkg::plru_t next_state
);

  // Walk the tree from the root
  always_comb begin
    if (state[0]) begin
      victim = {1'b1, state[2]};
    end else begin
      victim = {1'b0, state[1]};
    end
  end

  // Point root and branch away from the touched way
  always_comb begin
    next_state = state;
    next_state[0] = ~touch_way[1];
    if (touch_way[1]) begin
      next_state[2] = ~touch_way[0];
    end else begin
      next_state[1] = ~touch_way[0];
    end
  end

endmodule

`default_nettype wire

// File: cc_tag_dir.sv
`timescale 1ns/1ns
`default_nettype none

`include "cc_tag_params.svh"

module cc_tag_dir (
  input logic clk,
  input logic rst,
  input logic read_en,
  input cc_tag_pkg::line_addr_t read_addr,
  input logic write_en,
  input logic invalidate,
  input cc_tag_pkg::line_addr_t write_addr,
  output logic read_hit,
  output cc_tag_pkg::way_t read_way,
  output logic read_err,
  output logic evict_en,
  output cc_tag_pkg::line_addr_t evict_addr,
  output logic init_busy
);

  cc_tag_pkg::init_state_t init_state;
  cc_tag_pkg::index_t sweep_idx;

  logic lookup_en;
  logic fill_en;
  logic inval_en;
  logic fill_read_en;

  logic rd_valid_q;
  logic wr_valid_q;
  logic inv_q;
  cc_tag_pkg::tag_t rd_tag_q;
  cc_tag_pkg::index_t rd_index_q;
  cc_tag_pkg::tag_t wr_tag_q;
  cc_tag_pkg::index_t wr_index_q;

  cc_tag_pkg::index_t way_windex;
  logic way_clear;
  cc_tag_pkg::way_mask_t way_hit;
  cc_tag_pkg::way_mask_t way_err;
  cc_tag_pkg::way_mask_t way_match;
  cc_tag_pkg::way_mask_t way_invalid;
  cc_tag_pkg::way_mask_t way_we;
  cc_tag_pkg::tag_entry_t fill_entry [`CC_WAYS];

  cc_tag_pkg::plru_t plru_lookup;
  cc_tag_pkg::plru_t plru_fill;
  cc_tag_pkg::plru_t plru_lookup_next;
  cc_tag_pkg::plru_t plru_fill_next;
  cc_tag_pkg::plru_t plru_wdata;
  cc_tag_pkg::index_t plru_waddr;
  logic plru_we;
  cc_tag_pkg::way_t plru_victim;
  cc_tag_pkg::way_t fill_way;

  // Lowest set bit wins
  function automatic cc_tag_pkg::way_t first_way(input cc_tag_pkg::way_mask_t mask);
    cc_tag_pkg::way_t sel;
    sel = '0;
    for (int i = `CC_WAYS - 1; i >= 0; i--) begin
      if (mask[i]) begin
        sel = cc_tag_pkg::way_t'(i);
      end
    end
    return sel;
  endfunction

  assign init_busy = (init_state == cc_tag_pkg::INIT_SWEEP);
  assign lookup_en = read_en & ~init_busy;   // Requests dropped during the sweep
  assign fill_en = write_en & ~init_busy;
  assign inval_en = invalidate & ~init_busy;
  assign fill_read_en = fill_en | inval_en;

  // Init sweep, one set per cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      init_state <= cc_tag_pkg::INIT_SWEEP;
      sweep_idx <= '0;
    end else if (init_state == cc_tag_pkg::INIT_SWEEP) begin
      sweep_idx <= sweep_idx + 1'b1;
      if (sweep_idx == cc_tag_pkg::index_t'(`CC_SETS - 1)) begin
        init_state <= cc_tag_pkg::INIT_DONE;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_valid_q <= 1'b0;
      wr_valid_q <= 1'b0;
      inv_q <= 1'b0;
    end else begin
      rd_valid_q <= lookup_en;
      wr_valid_q <= fill_en;
      inv_q <= inval_en;
    end
  end

  always_ff @(posedge clk) begin
    if (lookup_en) begin
      rd_tag_q <= read_addr[`CC_LINE_W-1:`CC_INDEX_W];
      rd_index_q <= read_addr[`CC_INDEX_W-1:0];
    end
    if (fill_read_en) begin
      wr_tag_q <= write_addr[`CC_LINE_W-1:`CC_INDEX_W];
      wr_index_q <= write_addr[`CC_INDEX_W-1:0];
    end
  end

  assign way_windex = init_busy ? sweep_idx : wr_index_q;
  assign way_clear = init_busy | inv_q;

  for (genvar w = 0; w < `CC_WAYS; w++) begin : g_way
    cc_tag_way u_way (
      .clk(clk),
      .rst(rst),
      .read_en(lookup_en),
      .write_en(init_busy | way_we[w]),
      .clear(way_clear),
      .read_addr(read_addr[`CC_INDEX_W-1:0]),
      .read_tag(rd_tag_q),
      .fill_addr(write_addr[`CC_INDEX_W-1:0]),
      .fill_read_en(fill_read_en),
      .write_index(way_windex),
      .write_tag(wr_tag_q),
      .read_hit(way_hit[w]),
      .read_err(way_err[w]),
      .fill_entry(fill_entry[w])
    );

    assign way_match[w] = fill_entry[w][`CC_VALID_BIT] &&
                          (fill_entry[w][`CC_TAG_W-1:0] == wr_tag_q);
    assign way_invalid[w] = ~fill_entry[w][`CC_VALID_BIT];
    assign way_we[w] = (wr_valid_q && fill_way == cc_tag_pkg::way_t'(w)) ||
                       (inv_q && way_match[w]);
  end

  assign read_hit = rd_valid_q & ~init_busy & (|way_hit);
  assign read_err = rd_valid_q & ~init_busy & (|way_err);
  assign read_way = first_way(read_hit ? way_hit : '0);

  // Existing match, then first invalid way, then PLRU victim
  always_comb begin
    if (|way_match) begin
      fill_way = first_way(way_match);
    end else if (|way_invalid) begin
      fill_way = first_way(way_invalid);
    end else begin
      fill_way = plru_victim;
    end
  end

  assign evict_en = wr_valid_q & ~(|way_match) & ~(|way_invalid);
  assign evict_addr = {fill_entry[fill_way][`CC_TAG_W-1:0], wr_index_q};

  // PLRU copies, read beside the lookup and the fill
  cc_tag_ram #(
    .data_w(`CC_PLRU_W),
    .depth(`CC_SETS)
  ) u_plru_lookup_ram (
    .clk(clk),
    .rst(rst),
    .read_en(lookup_en),
    .write_en(plru_we),
    .read_addr(read_addr[`CC_INDEX_W-1:0]),
    .write_addr(plru_waddr),
    .write_data(plru_wdata),
    .read_data(plru_lookup)
  );

  cc_tag_ram #(
    .data_w(`CC_PLRU_W),
    .depth(`CC_SETS)
  ) u_plru_fill_ram (
    .clk(clk),
    .rst(rst),
    .read_en(fill_read_en),
    .write_en(plru_we),
    .read_addr(write_addr[`CC_INDEX_W-1:0]),
    .write_addr(plru_waddr),
    .write_data(plru_wdata),
    .read_data(plru_fill)
  );

  cc_plru u_plru_hit (
    .state(plru_lookup),
    .touch_way(read_way),
    .victim(),
    .next_state(plru_lookup_next)
  );

  cc_plru u_plru_repl (
    .state(plru_fill),
    .touch_way(fill_way),
    .victim(plru_victim),
    .next_state(plru_fill_next)
  );

  // Sweep first, a fill takes the single write port ahead of a lookup hit
  always_comb begin
    plru_we = 1'b0;
    plru_waddr = rd_index_q;
    plru_wdata = plru_lookup_next;
    if (init_busy) begin
      plru_we = 1'b1;
      plru_waddr = sweep_idx;
      plru_wdata = '0;
    end else if (wr_valid_q) begin
      plru_we = 1'b1;
      plru_waddr = wr_index_q;
      plru_wdata = plru_fill_next;
    end else if (read_hit) begin
      plru_we = 1'b1;
    end
  end

  a_no_fill_and_inval: assert property (@(posedge clk) disable iff (rst)
    !(write_en && invalidate));

  // Fills never duplicate a tag within a set
  a_hit_onehot: assert property (@(posedge clk) disable iff (rst)
    rd_valid_q |-> $onehot0(way_hit));

endmodule

`default_nettype wire

// File: tb_cc_tag_dir.sv
`timescale 1ns/1ns
`default_nettype none

`include "cc_tag_params.svh"

module tb_cc_tag_dir;

  localparam int clk_period = 40;
  localparam int test_cycles = 150; // Upper bound over all directed tests

  logic clk;
  logic rst;
  logic read_en;
  cc_tag_pkg::line_addr_t read_addr;
  logic write_en;
  logic invalidate;
  cc_tag_pkg::line_addr_t write_addr;
  logic read_hit;
  cc_tag_pkg::way_t read_way;
  logic read_err;
  logic evict_en;
  cc_tag_pkg::line_addr_t evict_addr;
  logic init_busy;

  int errors = 0;
  int tests_run = 0;
  int tests_failed = 0;
  logic [15:0] lfsr_state = 16'd42540;

  // Reference model of the directory
  logic m_valid [`CC_SETS][`CC_WAYS];
  cc_tag_pkg::tag_t m_tag [`CC_SETS][`CC_WAYS];
  cc_tag_pkg::plru_t m_plru [`CC_SETS];

  cc_tag_dir dut0 (
    .clk(clk),
    .rst(rst),
    .read_en(read_en),
    .read_addr(read_addr),
    .write_en(write_en),
    .invalidate(invalidate),
    .write_addr(write_addr),
    .read_hit(read_hit),
    .read_way(read_way),
    .read_err(read_err),
    .evict_en(evict_en),
    .evict_addr(evict_addr),
    .init_busy(init_busy)
  );

  always #(clk_period / 2) clk = ~clk;

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic random_tag(output cc_tag_pkg::tag_t t);
    for (int i = 0; i < `CC_TAG_W; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      t[i] = lfsr_state[0];
    end
  endtask

  // Root picks the half, branch bit picks the way, zero means lower
  function automatic cc_tag_pkg::way_t model_victim(input cc_tag_pkg::plru_t p);
    if (!p[0]) begin
      return p[1] ? 2'd1 : 2'd0;
    end
    return p[2] ? 2'd3 : 2'd2;
  endfunction

  function automatic cc_tag_pkg::plru_t model_touch(input cc_tag_pkg::plru_t p,
                                                    input cc_tag_pkg::way_t w);
    cc_tag_pkg::plru_t n;
    n = p;
    n[0] = (w < 2) ? 1'b1 : 1'b0;
    if (w < 2) begin
      n[1] = (w == 0) ? 1'b1 : 1'b0;
    end else begin
      n[2] = (w == 2) ? 1'b1 : 1'b0;
    end
    return n;
  endfunction

  function automatic logic model_find(input cc_tag_pkg::index_t s, input cc_tag_pkg::tag_t t,
                                      output cc_tag_pkg::way_t w);
    w = '0;
    for (int i = 0; i < `CC_WAYS; i++) begin
      if (m_valid[s][i] && m_tag[s][i] == t) begin
        w = cc_tag_pkg::way_t'(i);
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("[FAIL] %s expected %b actual %b", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_way(input string name, input cc_tag_pkg::way_t exp,
                           input cc_tag_pkg::way_t act);
    if (exp !== act) begin
      $display("[FAIL] %s expected way %0d actual way %0d", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_addr(input string name, input cc_tag_pkg::line_addr_t exp,
                            input cc_tag_pkg::line_addr_t act);
    if (exp !== act) begin
      $display("[FAIL] %s expected 0x%06h actual 0x%06h", name, exp, act);
      errors++;
    end
  endtask

  task automatic lookup(input string name, input cc_tag_pkg::line_addr_t addr);
    cc_tag_pkg::way_t w;
    logic hit;
    hit = model_find(addr[`CC_INDEX_W-1:0], addr[`CC_LINE_W-1:`CC_INDEX_W], w);
    @(negedge clk);
    read_en = 1'b1;
    read_addr = addr;
    @(negedge clk);
    read_en = 1'b0;
    check_bit({name, " hit"}, hit, read_hit);
    check_bit({name, " err"}, 1'b0, read_err);
    if (hit) begin
      check_way({name, " way"}, w, read_way);
      m_plru[addr[`CC_INDEX_W-1:0]] = model_touch(m_plru[addr[`CC_INDEX_W-1:0]], w);
    end
  endtask

  task automatic fill(input string name, input cc_tag_pkg::line_addr_t addr, input logic with_read,
                      input cc_tag_pkg::line_addr_t raddr);
    cc_tag_pkg::index_t s;
    cc_tag_pkg::tag_t t;
    cc_tag_pkg::way_t w;
    logic found;
    logic exp_evict;
    cc_tag_pkg::line_addr_t exp_addr;
    s = addr[`CC_INDEX_W-1:0];
    t = addr[`CC_LINE_W-1:`CC_INDEX_W];
    exp_evict = 1'b0;
    exp_addr = '0;
    found = model_find(s, t, w);
    for (int i = 0; i < `CC_WAYS; i++) begin
      if (!found && !m_valid[s][i]) begin
        w = cc_tag_pkg::way_t'(i);
        found = 1'b1;
      end
    end
    if (!found) begin
      w = model_victim(m_plru[s]);
      exp_evict = 1'b1;
      exp_addr = {m_tag[s][w], s};
    end
    @(negedge clk);
    write_en = 1'b1;
    write_addr = addr;
    read_en = with_read;
    read_addr = raddr;
    @(negedge clk);
    write_en = 1'b0;
    read_en = 1'b0;
    check_bit({name, " evict_en"}, exp_evict, evict_en);
    if (exp_evict) begin
      check_addr({name, " evict_addr"}, exp_addr, evict_addr);
    end
    m_valid[s][w] = 1'b1;
    m_tag[s][w] = t;
    m_plru[s] = model_touch(m_plru[s], w); // Fill owns the PLRU write port this cycle
  endtask

  task automatic invalidate_line(input string name, input cc_tag_pkg::line_addr_t addr);
    cc_tag_pkg::way_t w;
    @(negedge clk);
    invalidate = 1'b1;
    write_addr = addr;
    @(negedge clk);
    invalidate = 1'b0;
    check_bit({name, " evict_en"}, 1'b0, evict_en);
    if (model_find(addr[`CC_INDEX_W-1:0], addr[`CC_LINE_W-1:`CC_INDEX_W], w)) begin
      m_valid[addr[`CC_INDEX_W-1:0]][w] = 1'b0;
    end
  endtask

  task automatic report(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("%s: pass", name);
    end else begin
      $display("%s: fail, %0d mismatches", name, errors - errors_before);
      tests_failed++;
    end
  endtask

  function automatic cc_tag_pkg::line_addr_t line(input int way, input int s);
    return {m_tag[s][way], cc_tag_pkg::index_t'(s)};
  endfunction

  // One set per cycle, busy drops after the last set
  task automatic test_init_sweep();
    int e0;
    e0 = errors;
    check_bit("init_sweep busy", 1'b1, init_busy);
    repeat (`CC_SETS - 1) @(negedge clk);
    check_bit("init_sweep busy", 1'b1, init_busy);
    check_bit("init_sweep hit", 1'b0, read_hit);
    check_bit("init_sweep evict_en", 1'b0, evict_en);
    @(negedge clk);
    check_bit("init_sweep done", 1'b0, init_busy);
    report("init_sweep", e0);
  endtask

  task automatic test_after_init();
    cc_tag_pkg::tag_t t;
    int e0;
    e0 = errors;
    for (int s = 0; s < 64; s += 13) begin
      random_tag(t);
      lookup("after_init", {t, cc_tag_pkg::index_t'(s)});
    end
    report("after_init", e0);
  endtask

  task automatic test_fill_lookup(input int s);
    cc_tag_pkg::tag_t tags [4];
    int e0;
    e0 = errors;
    for (int i = 0; i < 4; i++) begin
      random_tag(tags[i]);
      tags[i][1:0] = i[1:0]; // Keeps the four tags distinct
      fill("fill_lookup", {tags[i], cc_tag_pkg::index_t'(s)}, 1'b0, '0);
    end
    for (int i = 0; i < 4; i++) begin
      lookup("fill_lookup", {tags[i], cc_tag_pkg::index_t'(s)});
      check_way("fill_lookup order", cc_tag_pkg::way_t'(i), read_way);
    end
    report("fill_lookup", e0);
  endtask

  task automatic test_replacement(input int s);
    cc_tag_pkg::tag_t t;
    cc_tag_pkg::line_addr_t victim_line;
    int e0;
    e0 = errors;
    lookup("replacement", line(2, s));
    lookup("replacement", line(0, s));
    lookup("replacement", line(3, s));
    lookup("replacement", line(1, s));
    victim_line = line(model_victim(m_plru[s]), s);
    random_tag(t);
    t[1:0] = 2'b00;
    t[17] = ~m_tag[s][0][17];
    fill("replacement", {t, cc_tag_pkg::index_t'(s)}, 1'b0, '0);
    lookup("replacement evicted", victim_line);
    lookup("replacement new", {t, cc_tag_pkg::index_t'(s)});
    report("replacement", e0);
  endtask

  task automatic test_invalidate(input int s);
    cc_tag_pkg::line_addr_t gone;
    int e0;
    e0 = errors;
    gone = line(1, s);
    invalidate_line("invalidate", gone);
    lookup("invalidate gone", gone);
    lookup("invalidate keep", line(0, s));
    lookup("invalidate keep", line(2, s));
    lookup("invalidate keep", line(3, s));
    invalidate_line("invalidate absent", {~m_tag[s][0], cc_tag_pkg::index_t'(s)});
    lookup("invalidate absent", line(0, s));
    lookup("invalidate absent", line(3, s));
    report("invalidate", e0);
  endtask

  task automatic test_refill(input int s);
    cc_tag_pkg::line_addr_t addr;
    int e0;
    e0 = errors;
    addr = line(2, s);
    fill("refill", addr, 1'b0, '0);
    lookup("refill", addr);
    report("refill", e0);
  endtask

  task automatic test_read_write(input int rs, input int ws);
    cc_tag_pkg::tag_t t;
    cc_tag_pkg::line_addr_t raddr;
    int e0;
    e0 = errors;
    raddr = line(3, rs);
    random_tag(t);
    fill("read_write fill", {t, cc_tag_pkg::index_t'(ws)}, 1'b1, raddr);
    check_bit("read_write hit", 1'b1, read_hit);
    check_way("read_write way", 2'd3, read_way);
    @(negedge clk);
    lookup("read_write later", {t, cc_tag_pkg::index_t'(ws)});
    lookup("read_write other", raddr);
    report("read_write", e0);
  endtask

  initial begin
    #((64 + test_cycles + 100) * clk_period);
    $display("Watchdog expired before the tests finished");
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    read_en = 1'b0;
    read_addr = '0;
    write_en = 1'b0;
    invalidate = 1'b0;
    write_addr = '0;
    for (int s = 0; s < `CC_SETS; s++) begin
      m_plru[s] = '0;
      for (int w = 0; w < `CC_WAYS; w++) begin
        m_valid[s][w] = 1'b0;
        m_tag[s][w] = '0;
      end
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    test_init_sweep();
    while (init_busy) @(negedge clk);

    test_after_init();
    test_fill_lookup(5);
    test_replacement(5);
    test_invalidate(5);
    test_refill(5);
    test_read_write(5, 9);

    $display("%0d tests, %0d failed, %0d mismatches", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
+incdir+.
cc_tag_pkg.sv
cc_tag_ram.sv
cc_tag_way.sv
cc_plru.sv
cc_tag_dir.sv
tb_cc_tag_dir.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the tag directory testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f files.f --top-module tb_cc_tag_dir \
  -o sim_tb_cc_tag_dir \
  && ./obj_dir/sim_tb_cc_tag_dir | tee /dev/stderr | grep -q "TEST OK" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
